//--- tb.f
+incdir+.
mips32IsaPkg.sv
mips32PipePkg.sv
stageReg.sv
fetchUnit.sv
controlDecode.sv
registerFile.sv
hazardForward.sv
executeUnit.sv
sharedMemory.sv
mips32Top.sv
mips32Tb.sv

//--- mips32Tb.sv
// Testbench for the MIPS32 core, checks retired writes against an in-order model
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module mips32Tb import mips32IsaPkg::*; ();

	logic               clk = 1'b0;
	logic               rstN;
	logic               coreRun;
	logic               progWe;
	logic [`DATA_W-1:0] progAddr;
	logic [`DATA_W-1:0] progData;
	logic               wbValid;
	logic [4:0]         wbReg;
	logic [`DATA_W-1:0] wbData;

	logic [31:0] lfsr;
	logic [31:0] prog [32];
	logic [31:0] refMem [`MEM_WORDS];
	logic [4:0]  expReg [64];
	logic [31:0] expData [64];
	int          expCount = 0;
	int          retireIdx = 0;
	int          errors = 0;
	int          timeouts = 0;
	int          cycles;

	mips32Top dut_i (
		.clk, .rstN, .coreRun, .progWe, .progAddr, .progData, .wbValid, .wbReg, .wbData
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (!rstN) begin
			retireIdx <= 0;
		end else if (wbValid) begin
			retireIdx <= retireIdx + 1;
		end
	end

	// Checked on the falling edge, away from every input change
	retireExpected: assert property (@(negedge clk) disable iff (!rstN)
		wbValid |-> (retireIdx < expCount))
		else begin
			errors++;
			$display("A register write to r%0d retired after all expected writes", wbReg);
		end

	zeroNeverRetires: assert property (@(negedge clk) disable iff (!rstN)
		wbValid |-> (wbReg != 5'd0))
		else begin
			errors++;
			$display("A write to register 0 produced a retire pulse");
		end

	regMatches: assert property (@(negedge clk) disable iff (!rstN)
		(wbValid && retireIdx < expCount) |-> (wbReg == expReg[retireIdx]))
		else begin
			errors++;
			$display("[ERROR] t=%0t wbReg expected %0d actual %0d", $time,
				expReg[retireIdx], wbReg);
		end

	dataMatches: assert property (@(negedge clk) disable iff (!rstN)
		(wbValid && retireIdx < expCount) |-> (wbData == expData[retireIdx]))
		else begin
			errors++;
			$display("[ERROR] t=%0t wbData expected %h actual %h", $time,
				expData[retireIdx], wbData);
		end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic randImm(output logic [15:0] v);
		for (int i = 0; i < 16; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic logic [31:0] rOp(input logic [5:0] fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	// Operand order follows the assembly form op rt, rs, imm
	function automatic logic [31:0] iOp(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic buildProgram();
		logic [15:0] k [4];
		for (int i = 0; i < 4; i++) begin
			randImm(k[i]);
		end
		for (int i = 0; i < 32; i++) begin
			prog[i] = '0;
		end
		prog[0]  = iOp(opAddiu, 1, 0, k[0]);
		prog[1]  = iOp(opAddiu, 2, 0, k[1]);
		prog[2]  = rOp(fnAddu, 3, 1, 2);
		prog[3]  = rOp(fnSubu, 4, 3, 1);
		prog[4]  = rOp(fnAnd, 5, 4, 3);
		prog[5]  = rOp(fnOr, 6, 5, 4);
		prog[6]  = rOp(fnSlt, 7, 6, 1);
		prog[7]  = iOp(opAddiu, 8, 7, k[2]);
		prog[8]  = iOp(opAddiu, 0, 8, k[3]);
		prog[9]  = rOp(fnAddu, 9, 0, 8);
		prog[10] = iOp(opSw, 9, 0, 16'h0800);
		prog[11] = iOp(opLw, 10, 0, 16'h0800);
		prog[12] = rOp(fnAddu, 11, 10, 9);
		// Taken, skips words 14 and 15
		prog[13] = iOp(opBeq, 9, 10, 16'd2);
		prog[14] = iOp(opAddiu, 12, 0, 16'd1);
		prog[15] = iOp(opAddiu, 13, 0, 16'd2);
		prog[16] = iOp(opAddiu, 14, 1, 16'd1);
		prog[17] = iOp(opBeq, 1, 14, 16'd2);
		prog[18] = rOp(fnAddu, 15, 14, 11);
		prog[19] = {opJ, 26'd22};
		prog[20] = iOp(opAddiu, 16, 0, 16'd5);
		prog[21] = iOp(opAddiu, 17, 0, 16'd6);
		prog[22] = iOp(opAddiu, 18, 15, k[0] ^ k[2]);
		prog[23] = rOp(fnSlt, 19, 18, 2);
		// Jump to itself ends the program
		prog[24] = {opJ, 26'd24};
	endtask

	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0]  dest;
		logic        wr;
		int          pc;
		int          next;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		for (int step = 0; step < 200; step++) begin
			ins  = prog[pc];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			imm  = {{16{ins[15]}}, ins[15:0]};
			wr   = 1'b0;
			dest = ins[20:16];
			res  = '0;
			next = pc + 1;
			case (ins[31:26])
				opRType: begin
					wr   = 1'b1;
					dest = ins[15:11];
					case (ins[5:0])
						fnAddu:  res = a + b;
						fnSubu:  res = a - b;
						fnAnd:   res = a & b;
						fnOr:    res = a | b;
						default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				opAddiu: begin
					wr  = 1'b1;
					res = a + imm;
				end
				opLw: begin
					wr  = 1'b1;
					res = refMem[((a + imm) >> 2) % `MEM_WORDS];
				end
				opSw: refMem[((a + imm) >> 2) % `MEM_WORDS] = b;
				opBeq: begin
					if (a == b) begin
						next = pc + 1 + $signed(ins[15:0]);
					end
				end
				opJ: begin
					if (int'(ins[25:0]) == pc) begin
						return;
					end
					next = int'(ins[25:0]);
				end
				default: wr = 1'b0;
			endcase
			if (wr && dest != 5'd0) begin
				regs[dest]        = res;
				expReg[expCount]  = dest;
				expData[expCount] = res;
				expCount++;
			end
			pc = next;
		end
	endtask

	initial begin
		rstN     = 1'b0;
		coreRun  = 1'b0;
		progWe   = 1'b0;
		progAddr = '0;
		progData = '0;
		lfsr     = 32'hfb60;
		buildProgram();
		runModel();
		repeat (2) @(posedge clk);
		#2;
		rstN = 1'b1;
		// Loader owns the memory while the core is idle
		for (int i = 0; i < 32; i++) begin
			@(posedge clk);
			#2;
			progWe   = 1'b1;
			progAddr = i;
			progData = prog[i];
		end
		@(posedge clk);
		#2;
		progWe  = 1'b0;
		coreRun = 1'b1;
		cycles  = 0;
		while (retireIdx < expCount && cycles < 500) begin
			@(posedge clk);
			cycles++;
		end
		if (retireIdx < expCount) begin
			timeouts++;
			$display("Timed out with %0d of %0d register writes retired", retireIdx, expCount);
		end
		// Leave room for a stray write from a squashed instruction
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
		end
		$display("Retired %0d of %0d writes, errors %0d, timeouts %0d", retireIdx, expCount,
			errors, timeouts);
		if (errors == 0 && timeouts == 0 && retireIdx == expCount) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- mips32Top.sv
// Five-stage MIPS32 core built around one shared memory
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module mips32Top import mips32IsaPkg::*; import mips32PipePkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic               coreRun,
	input  logic               progWe,
	input  logic [`DATA_W-1:0] progAddr,
	input  logic [`DATA_W-1:0] progData,
	output logic               wbValid,
	output logic [4:0]         wbReg,
	output logic [`DATA_W-1:0] wbData
);

	ifIdT               ifD, ifQ;
	idExT               idExD, idExQ;
	exMemT              exMemD, exMemQ;
	memWbT              memWbD, memWbQ;
	ctrlT               decCtrl;
	fwdSelT             fwdRs, fwdRt;
	logic               pcStall, ifIdStall, ifIdFlush, idExFlush;
	logic               branchTaken, jumpTaken, redirect;
	logic               fetchReq, fetchGnt, dataReq, dataWe;
	logic [`DATA_W-1:0] decImm, jumpTarget, rsVal, rtVal, branchPc, redirectPc;
	logic [`DATA_W-1:0] fetchAddr, fetchData, dataAddr, dataRdata;

	// Older branch in execute wins over a jump in decode
	assign jumpTaken  = ifQ.valid && decCtrl.isJump;
	assign redirect   = branchTaken || jumpTaken;
	assign redirectPc = branchTaken ? branchPc : jumpTarget;

	fetchUnit fetch_i (
		.clk, .rstN, .run(coreRun), .stall(pcStall), .redirect, .redirectPc,
		.fetchReq, .fetchAddr, .fetchGnt, .fetchData, .ifPayload(ifD)
	);

	stageReg #(.payloadT(ifIdT)) ifId_i (
		.clk, .rstN, .stall(ifIdStall), .flush(ifIdFlush), .d(ifD), .q(ifQ)
	);

	controlDecode decode_i (
		.instr(ifQ.instr), .pcPlus4(ifQ.pcPlus4), .ctrl(decCtrl), .imm(decImm), .jumpTarget
	);

	registerFile regFile_i (
		.clk, .rstN, .rsIdx(ifQ.instr[25:21]), .rtIdx(ifQ.instr[20:16]), .rsVal, .rtVal,
		.wbPayload(memWbQ), .wbValid, .wbReg, .wbData
	);

	assign idExD = '{valid: ifQ.valid, ctrl: decCtrl, pcPlus4: ifQ.pcPlus4, rsVal: rsVal,
		rtVal: rtVal, imm: decImm, rs: ifQ.instr[25:21], rt: ifQ.instr[20:16],
		rd: ifQ.instr[15:11]};

	hazardForward hazard_i (
		.decRs(ifQ.instr[25:21]), .decRt(ifQ.instr[20:16]), .decValid(ifQ.valid),
		.exPayload(idExQ), .memPayload(exMemQ), .wbPayload(memWbQ), .branchTaken, .jumpTaken,
		.pcStall, .ifIdStall, .ifIdFlush, .idExFlush, .fwdRs, .fwdRt
	);

	stageReg #(.payloadT(idExT)) idEx_i (
		.clk, .rstN, .stall(1'b0), .flush(idExFlush), .d(idExD), .q(idExQ)
	);

	executeUnit execute_i (
		.exPayload(idExQ), .fwdRs, .fwdRt, .memAluResult(exMemQ.aluResult), .wbData,
		.exMemNext(exMemD), .branchTaken, .branchPc
	);

	stageReg #(.payloadT(exMemT)) exMem_i (
		.clk, .rstN, .stall(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	// Byte address from the ALU becomes a word address
	assign dataReq  = exMemQ.valid && (exMemQ.ctrl.memRead || exMemQ.ctrl.memWrite);
	assign dataWe   = exMemQ.valid && exMemQ.ctrl.memWrite;
	assign dataAddr = exMemQ.aluResult >> 2;
	assign memWbD   = '{valid: exMemQ.valid, regWrite: exMemQ.ctrl.regWrite,
		memToReg: exMemQ.ctrl.memToReg, loadData: dataRdata, aluResult: exMemQ.aluResult,
		dest: exMemQ.dest};

	sharedMemory memory_i (
		.clk, .progWe, .progAddr, .progData, .dataReq, .dataWe, .dataAddr,
		.dataWdata(exMemQ.storeData), .dataRdata, .fetchReq, .fetchAddr, .fetchGnt, .fetchData
	);

	stageReg #(.payloadT(memWbT)) memWb_i (
		.clk, .rstN, .stall(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
	);

endmodule

//--- sharedMemory.sv
// Shared word memory with a fixed-priority arbiter for loader, data and fetch
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module sharedMemory (
	input  logic               clk,
	input  logic               progWe,
	input  logic [`DATA_W-1:0] progAddr,
	input  logic [`DATA_W-1:0] progData,
	input  logic               dataReq,
	input  logic               dataWe,
	input  logic [`DATA_W-1:0] dataAddr,
	input  logic [`DATA_W-1:0] dataWdata,
	output logic [`DATA_W-1:0] dataRdata,
	input  logic               fetchReq,
	input  logic [`DATA_W-1:0] fetchAddr,
	output logic               fetchGnt,
	output logic [`DATA_W-1:0] fetchData
);

	localparam int addrW = $clog2(`MEM_WORDS);

	logic [`DATA_W-1:0] mem [`MEM_WORDS];
	logic               dataGnt;
	logic               portWe;
	logic [`DATA_W-1:0] portAddr;
	logic [`DATA_W-1:0] portWdata;
	logic [`DATA_W-1:0] portRdata;

	// Loader first, then the memory stage, fetch last
	assign dataGnt  = dataReq && !progWe;
	assign fetchGnt = fetchReq && !progWe && !dataReq;

	always_comb begin
		if (progWe) begin
			portAddr = progAddr;
		end else if (dataGnt) begin
			portAddr = dataAddr;
		end else begin
			portAddr = fetchAddr;
		end
	end

	assign portWe    = progWe || (dataGnt && dataWe);
	assign portWdata = progWe ? progData : dataWdata;

	// One read port shared by both readers
	assign portRdata = mem[portAddr[addrW-1:0]];
	assign dataRdata = portRdata;
	assign fetchData = portRdata;

	always_ff @(posedge clk) begin
		if (portWe) begin
			mem[portAddr[addrW-1:0]] <= portWdata;
		end
	end

	// Loader only writes while the core leaves the memory alone
	loaderIdle: assert property (@(posedge clk)
		progWe |-> !(dataReq || fetchReq))
		else $error("sharedMemory: loader write while the core uses memory");

endmodule

//--- executeUnit.sv
// Execute stage with forwarding muxes, ALU and beq resolution
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module executeUnit import mips32IsaPkg::*; import mips32PipePkg::*; (
	input  idExT               exPayload,
	input  fwdSelT             fwdRs,
	input  fwdSelT             fwdRt,
	input  logic [`DATA_W-1:0] memAluResult,
	input  logic [`DATA_W-1:0] wbData,
	output exMemT              exMemNext,
	output logic               branchTaken,
	output logic [`DATA_W-1:0] branchPc
);

	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] rtFwd;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluResult;
	logic [4:0]         dest;

	function automatic logic [`DATA_W-1:0] fwdMux(input fwdSelT sel,
			input logic [`DATA_W-1:0] rfVal);
		case (sel)
			fwdMem:  return memAluResult;
			fwdWb:   return wbData;
			default: return rfVal;
		endcase
	endfunction

	always_comb begin
		opA   = fwdMux(fwdRs, exPayload.rsVal);
		rtFwd = fwdMux(fwdRt, exPayload.rtVal);
		opB   = exPayload.ctrl.aluSrcImm ? exPayload.imm : rtFwd;
		case (exPayload.ctrl.aluOp)
			aluAdd:  aluResult = opA + opB;
			aluSub:  aluResult = opA - opB;
			aluAnd:  aluResult = opA & opB;
			aluOr:   aluResult = opA | opB;
			aluSlt:  aluResult = {{(`DATA_W-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluResult = '0;
		endcase
	end

	assign branchTaken = exPayload.valid && exPayload.ctrl.isBranch && (opA == rtFwd);
	assign branchPc    = exPayload.pcPlus4 + (exPayload.imm << 2);
	assign dest        = exPayload.ctrl.regDstRd ? exPayload.rd : exPayload.rt;

	// Store data takes the forwarded rt value
	assign exMemNext = '{valid: exPayload.valid, ctrl: exPayload.ctrl, aluResult: aluResult,
		storeData: rtFwd, dest: dest};

endmodule

//--- hazardForward.sv
// Load-use stall, branch and jump flushes, and operand forwarding selects
`timescale 1ns/10ps

module hazardForward import mips32PipePkg::*; (
	input  logic [4:0] decRs,
	input  logic [4:0] decRt,
	input  logic       decValid,
	input  idExT       exPayload,
	input  exMemT      memPayload,
	input  memWbT      wbPayload,
	input  logic       branchTaken,
	input  logic       jumpTaken,
	output logic       pcStall,
	output logic       ifIdStall,
	output logic       ifIdFlush,
	output logic       idExFlush,
	output fwdSelT     fwdRs,
	output fwdSelT     fwdRt
);

	logic loadUse;

	// Decode is squashed anyway when a branch or jump redirects
	assign loadUse = decValid && exPayload.valid && exPayload.ctrl.memRead &&
		(exPayload.rt != '0) && ((exPayload.rt == decRs) || (exPayload.rt == decRt)) &&
		!branchTaken && !jumpTaken;

	assign pcStall   = loadUse;
	assign ifIdStall = loadUse;
	assign ifIdFlush = branchTaken || jumpTaken;
	assign idExFlush = branchTaken || loadUse;

	// Memory stage is younger, so it beats write-back
	function automatic fwdSelT pickSource(input logic [4:0] idx);
		fwdSelT sel;
		if (idx == '0) begin
			sel = fwdRf;
		end else if (memPayload.valid && memPayload.ctrl.regWrite &&
				memPayload.dest == idx) begin
			sel = fwdMem;
		end else if (wbPayload.valid && wbPayload.regWrite && wbPayload.dest == idx) begin
			sel = fwdWb;
		end else begin
			sel = fwdRf;
		end
		return sel;
	endfunction

	always_comb begin
		fwdRs = pickSource(exPayload.rs);
		fwdRt = pickSource(exPayload.rt);
	end

	// A load never feeds execute through the memory stage bypass
	always_comb begin
		if (!$isunknown({exPayload.valid, exPayload.ctrl, memPayload.valid,
				memPayload.ctrl, fwdRs, fwdRt})) begin
			loadNotBypassed: assert final (!(exPayload.valid && !exPayload.ctrl.isJump &&
				memPayload.valid && memPayload.ctrl.memRead &&
				(fwdRs == fwdMem || fwdRt == fwdMem)))
				else $error("hazardForward: load data bypassed from the memory stage");
		end
	end

endmodule

//--- registerFile.sv
// General register file with write-back select and retire port
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module registerFile import mips32PipePkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic [4:0]         rsIdx,
	input  logic [4:0]         rtIdx,
	output logic [`DATA_W-1:0] rsVal,
	output logic [`DATA_W-1:0] rtVal,
	input  memWbT              wbPayload,
	output logic               wbValid,
	output logic [4:0]         wbReg,
	output logic [`DATA_W-1:0] wbData
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	assign wbReg   = wbPayload.dest;
	assign wbData  = wbPayload.memToReg ? wbPayload.loadData : wbPayload.aluResult;
	// Writes to r0 are dropped and never retire
	assign wbValid = wbPayload.valid && wbPayload.regWrite && (wbPayload.dest != '0);

	// Same-cycle write is visible to decode
	assign rsVal = (rsIdx == '0) ? '0 : (wbValid && wbReg == rsIdx) ? wbData : regs[rsIdx];
	assign rtVal = (rtIdx == '0) ? '0 : (wbValid && wbReg == rtIdx) ? wbData : regs[rtIdx];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid) begin
			regs[wbReg] <= wbData;
		end
	end

endmodule

//--- controlDecode.sv
// Instruction decode into the control bundle, immediate and jump target
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module controlDecode import mips32IsaPkg::*; (
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] pcPlus4,
	output ctrlT               ctrl,
	output logic [`DATA_W-1:0] imm,
	output logic [`DATA_W-1:0] jumpTarget
);

	opcodeT opcode;
	functT  funct;

	assign opcode     = opcodeT'(instr[31:26]);
	assign funct      = functT'(instr[5:0]);
	assign imm        = {{16{instr[15]}}, instr[15:0]};
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		ctrl = '0;
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (funct)
					fnAddu:  ctrl.aluOp = aluAdd;
					fnSubu:  ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnSlt:   ctrl.aluOp = aluSlt;
					default: ctrl = '0;
				endcase
			end
			opAddiu: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opLw: begin
				ctrl.regWrite  = 1'b1;
				ctrl.memToReg  = 1'b1;
				ctrl.memRead   = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opSw: begin
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opBeq: begin
				ctrl.isBranch = 1'b1;
				ctrl.aluOp    = aluSub;
			end
			opJ:     ctrl.isJump = 1'b1;
			// Unknown opcodes become a bubble
			default: ctrl = '0;
		endcase
	end

endmodule

//--- fetchUnit.sv
// Program counter and instruction fetch over the shared memory port
`timescale 1ns/10ps
`include "mips32_cfg.svh"

module fetchUnit import mips32PipePkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic               run,
	input  logic               stall,
	input  logic               redirect,
	input  logic [`DATA_W-1:0] redirectPc,
	output logic               fetchReq,
	output logic [`DATA_W-1:0] fetchAddr,
	input  logic               fetchGnt,
	input  logic [`DATA_W-1:0] fetchData,
	output ifIdT               ifPayload
);

	logic [`DATA_W-1:0] pc;
	logic [`DATA_W-1:0] pcPlus4;

	assign pcPlus4   = pc + 'd4;
	assign fetchReq  = run && !stall;
	assign fetchAddr = pc >> 2;

	// No grant means an empty slot and the PC holds
	assign ifPayload = '{valid: fetchReq && fetchGnt, pcPlus4: pcPlus4, instr: fetchData};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (fetchReq && fetchGnt) begin
			pc <= pcPlus4;
		end
	end

	fetchInRange: assert property (@(posedge clk) disable iff (!rstN)
		fetchReq |-> (fetchAddr < `MEM_WORDS))
		else $error("fetchUnit: fetch address %0h outside memory", fetchAddr);

endmodule

//--- stageReg.sv
// Pipeline stage register with stall hold and flush to an empty slot
`timescale 1ns/10ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    stall,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// All-zero payload is an invalid slot
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;
		end
	end

	// Hazard logic never holds a slot that it squashes
	noStallOnFlush: assert property (@(posedge clk) disable iff (!rstN)
		!(stall && flush))
		else $error("stageReg: stall and flush high together");

endmodule

//--- mips32PipePkg.sv
// Pipeline stage payloads and the operand forwarding select
`include "mips32_cfg.svh"

package mips32PipePkg;
	import mips32IsaPkg::*;

	typedef struct packed {
		logic               valid;
		logic [`DATA_W-1:0] pcPlus4;
		logic [`DATA_W-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic               valid;
		ctrlT               ctrl;
		logic [`DATA_W-1:0] pcPlus4;
		logic [`DATA_W-1:0] rsVal;
		logic [`DATA_W-1:0] rtVal;
		logic [`DATA_W-1:0] imm;
		logic [4:0]         rs;
		logic [4:0]         rt;
		logic [4:0]         rd;
	} idExT;

	typedef struct packed {
		logic               valid;
		ctrlT               ctrl;
		logic [`DATA_W-1:0] aluResult;
		logic [`DATA_W-1:0] storeData;
		logic [4:0]         dest;
	} exMemT;

	typedef struct packed {
		logic               valid;
		logic               regWrite;
		logic               memToReg;
		logic [`DATA_W-1:0] loadData;
		logic [`DATA_W-1:0] aluResult;
		logic [4:0]         dest;
	} memWbT;

	typedef enum logic [1:0] {
		fwdRf  = 2'd0,
		fwdMem = 2'd1,
		fwdWb  = 2'd2
	} fwdSelT;

endpackage

//--- mips32IsaPkg.sv
// MIPS32 instruction encodings and the decoded control bundle
package mips32IsaPkg;

	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opAddiu = 6'h09,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// All zero means a bubble with no side effects
	typedef struct packed {
		logic  regWrite;
		logic  memToReg;
		logic  memRead;
		logic  memWrite;
		logic  aluSrcImm;
		logic  regDstRd;
		logic  isBranch;
		logic  isJump;
		aluOpT aluOp;
	} ctrlT;

endpackage

//--- mips32_cfg.svh
// Core configuration for the MIPS32 pipeline and its shared memory
`ifndef MIPS32_CFG_SVH
`define MIPS32_CFG_SVH

// Datapath width in bits
`define DATA_W 32

// Shared memory depth in words
`define MEM_WORDS 1024

// General purpose registers
`define REG_COUNT 32

// First fetch address
`define RESET_PC 32'h0000_0000

`endif
